// ==== histBuilder.sv ====
`timescale 1ns/100ps
`include "sifh_settings.svh"

module histBuilder (
    input  logic           clk,
    input  logic           res,
    input  logic           buildStart,
    input  logic           buildFine,
    input  sifhPkg::binT   buildWindow,
    input  logic           tdcReq,
    input  sifhPkg::codeT  tdcCode,
    output logic           tdcAck,
    output logic           tdcEnable,
    output logic           we,
    output sifhPkg::binT   waddr,
    output sifhPkg::countT wdata,
    output logic           re,
    output sifhPkg::binT   raddr,
    input  sifhPkg::countT rdata,
    output logic           buildDone
);

    localparam int EvW = $clog2(`EVENTS_PER_PASS + 1);

    typedef enum logic [2:0] {
        sIdle,
        sClear,
        sWait,
        sRead,
        sIncr,
        sWrite,
        sAck,
        sDone
    } stateT;

    stateT          state;
    sifhPkg::binT   clrAddr;   // clear sweep pointer
    logic [EvW-1:0] evCount;   // offered events this pass
    sifhPkg::binT   evBin;     // bin of the event in flight
    logic           evInWin;   // event is binned, not discarded
    sifhPkg::countT incCount;  // bin content after increment
    sifhPkg::binT   codeHi;
    sifhPkg::binT   codeLo;

    assign codeHi = tdcCode[`CODE_W-1 -: `BIN_W];
    assign codeLo = tdcCode[`BIN_W-1:0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sIdle;
            clrAddr   <= '0;
            evCount   <= '0;
            tdcAck    <= 1'b0;
            buildDone <= 1'b0;
        end else begin
            buildDone <= 1'b0;
            case (state)
                sIdle: begin
                    if (buildStart) begin
                        clrAddr <= '0;
                        evCount <= '0;
                        state   <= sClear;
                    end
                end
                sClear: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == '1) begin
                        state <= sWait;  // all bins zero
                    end
                end
                sWait: begin
                    if (tdcReq) begin
                        state <= sRead;
                    end
                end
                sRead: state <= sIncr;
                sIncr: state <= sWrite;
                sWrite: begin
                    tdcAck <= 1'b1;  // 3rd edge after req sampled
                    state  <= sAck;
                end
                sAck: begin
                    if (!tdcReq) begin
                        tdcAck <= 1'b0;
                        if (evCount == EvW'(`EVENTS_PER_PASS - 1)) begin
                            state <= sDone;
                        end else begin
                            evCount <= evCount + 1'b1;
                            state   <= sWait;
                        end
                    end
                end
                sDone: begin
                    buildDone <= 1'b1;
                    state     <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sWait && tdcReq) begin
            evBin   <= buildFine ? codeLo : codeHi;
            evInWin <= !buildFine || (codeHi == buildWindow);
        end
        if (state == sIncr) begin
            incCount <= (rdata == '1) ? rdata : rdata + 1'b1;  // saturate
        end
    end

    assign tdcEnable = state inside {sWait, sRead, sIncr, sWrite, sAck};

    // discarded fine events walk the same states with the SRAM idle
    assign we    = (state == sClear) || (state == sWrite && evInWin);
    assign waddr = (state == sClear) ? clrAddr : evBin;
    assign wdata = (state == sClear) ? '0 : incCount;
    assign re    = (state == sRead) && evInWin;
    assign raddr = evBin;

    // ack only answers a request held through the whole read-modify-write
    ackAfterReq: assert property (@(posedge clk) disable iff (!res)
        $rose(tdcAck) |-> $past(tdcReq) && $past(tdcReq, 2) && $past(tdcReq, 3));
    noRwCollide: assert property (@(posedge clk) disable iff (!res)
        !(we && re && waddr == raddr));

endmodule

// ==== histRam.sv ====
`timescale 1ns/100ps
`include "sifh_settings.svh"

module histRam (
    input  logic           clk,
    input  logic           we,
    input  sifhPkg::binT   waddr,
    input  sifhPkg::countT wdata,
    input  logic           re,
    input  sifhPkg::binT   raddr,
    output sifhPkg::countT rdata
);

    sifhPkg::countT mem [0:(1 << `BIN_W) - 1];  // one word per bin

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];  // old data on a same-cycle write
        end
    end

    // a floating address would corrupt or read a random bin
    waddrKnown: assert property (@(posedge clk) we |-> !$isunknown(waddr));
    raddrKnown: assert property (@(posedge clk) re |-> !$isunknown(raddr));

endmodule

// ==== peakFinder.sv ====
`timescale 1ns/100ps

module peakFinder (
    input  logic           clk,
    input  logic           res,
    input  logic           scanStart,
    output logic           re,
    output sifhPkg::binT   raddr,
    input  sifhPkg::countT rdata,
    output logic           scanDone,
    output sifhPkg::binT   peakBin,
    output sifhPkg::countT peakCount
);

    logic         busy;     // read sweep running
    sifhPkg::binT addr;
    logic         rdValid;  // rdata belongs to rdBin
    sifhPkg::binT rdBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy      <= 1'b0;
            addr      <= '0;
            rdValid   <= 1'b0;
            rdBin     <= '0;
            scanDone  <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            scanDone <= 1'b0;
            rdValid  <= busy;
            rdBin    <= addr;
            if (busy) begin
                addr <= addr + 1'b1;
                if (addr == '1) begin
                    busy <= 1'b0;
                end
            end else if (scanStart) begin
                busy      <= 1'b1;
                addr      <= '0;
                peakBin   <= '0;
                peakCount <= '0;
            end
            if (rdValid) begin
                if (rdata > peakCount) begin  // strict, ties keep lower bin
                    peakBin   <= rdBin;
                    peakCount <= rdata;
                end
                if (rdBin == '1) begin
                    scanDone <= 1'b1;  // last bin compared
                end
            end
        end
    end

    assign re    = busy;
    assign raddr = addr;

    noAddrWrap: assert property (@(posedge clk) disable iff (!res)
        re && raddr == '1 |=> !re);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the histogram engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbSifh -f sources.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== sifhControl.sv ====
`timescale 1ns/100ps

module sifhControl (
    input  logic           clk,
    input  logic           res,
    output logic           buildStart,
    output sifhPkg::binT   buildWindow,
    output logic           buildFine,
    input  logic           buildDone,
    output logic           scanStart,
    input  logic           scanDone,
    input  sifhPkg::binT   peakBin,
    input  sifhPkg::countT peakCount,
    input  logic           bldWe,
    input  sifhPkg::binT   bldWaddr,
    input  sifhPkg::countT bldWdata,
    input  logic           bldRe,
    input  sifhPkg::binT   bldRaddr,
    input  logic           fndRe,
    input  sifhPkg::binT   fndRaddr,
    output logic           ramWe,
    output sifhPkg::binT   ramWaddr,
    output sifhPkg::countT ramWdata,
    output logic           ramRe,
    output sifhPkg::binT   ramRaddr,
    output logic           resultReq,
    input  logic           resultAck,
    output sifhPkg::codeT  resultCode,
    output sifhPkg::countT resultCount,
    output sifhPkg::countT coarseCount
);

    sifhPkg::phaseT phase;
    sifhPkg::phaseT phaseNext;
    logic           phaseNew;   // first cycle of a phase
    logic           clearEnd;   // last clear write of the builder
    logic           bldOwn;
    logic           fndOwn;
    sifhPkg::binT   coarseBin;  // becomes the fine window
    sifhPkg::countT coarseCnt;

    assign clearEnd = bldWe && (bldWaddr == '1);

    always_comb begin
        phaseNext = phase;
        case (phase)
            sifhPkg::clearCoarse: if (clearEnd)  phaseNext = sifhPkg::buildCoarse;
            sifhPkg::buildCoarse: if (buildDone) phaseNext = sifhPkg::peakCoarse;
            sifhPkg::peakCoarse:  if (scanDone)  phaseNext = sifhPkg::clearFine;
            sifhPkg::clearFine:   if (clearEnd)  phaseNext = sifhPkg::buildFine;
            sifhPkg::buildFine:   if (buildDone) phaseNext = sifhPkg::peakFine;
            sifhPkg::peakFine:    if (scanDone)  phaseNext = sifhPkg::report;
            sifhPkg::report: begin
                if (!resultReq && !resultAck) begin
                    phaseNext = sifhPkg::clearCoarse;  // handshake closed
                end
            end
            default: phaseNext = sifhPkg::clearCoarse;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase     <= sifhPkg::clearCoarse;
            phaseNew  <= 1'b1;  // kicks the first clear
            resultReq <= 1'b0;
        end else begin
            phase    <= phaseNext;
            phaseNew <= (phaseNext != phase);
            if (phase == sifhPkg::peakFine && scanDone) begin
                resultReq <= 1'b1;
            end else if (resultReq && resultAck) begin
                resultReq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == sifhPkg::peakCoarse && scanDone) begin
            coarseBin <= peakBin;
            coarseCnt <= peakCount;
        end
    end

    assign buildStart  = phaseNew && (phase == sifhPkg::clearCoarse || phase == sifhPkg::clearFine);
    assign scanStart   = phaseNew && (phase == sifhPkg::peakCoarse || phase == sifhPkg::peakFine);
    assign buildFine   = (phase == sifhPkg::clearFine) || (phase == sifhPkg::buildFine);
    assign buildWindow = coarseBin;

    // SRAM port ownership by phase
    assign bldOwn = phase inside {sifhPkg::clearCoarse, sifhPkg::buildCoarse,
                                  sifhPkg::clearFine, sifhPkg::buildFine};
    assign fndOwn = (phase == sifhPkg::peakCoarse) || (phase == sifhPkg::peakFine);

    assign ramWe    = bldOwn && bldWe;
    assign ramWaddr = bldWaddr;
    assign ramWdata = bldWdata;
    assign ramRe    = (bldOwn && bldRe) || (fndOwn && fndRe);
    assign ramRaddr = fndOwn ? fndRaddr : bldRaddr;

    // finder holds its peak until the next scan, past the result handshake
    assign resultCode  = {coarseBin, peakBin};
    assign resultCount = peakCount;
    assign coarseCount = coarseCnt;

    oneMaster: assert property (@(posedge clk) disable iff (!res)
        !((bldWe || bldRe) && fndRe));
    resultHeld: assert property (@(posedge clk) disable iff (!res)
        resultReq && !resultAck |=> resultReq && $stable(resultCode)
            && $stable(resultCount) && $stable(coarseCount));

endmodule

// ==== sifhPkg.sv ====
`include "sifh_settings.svh"

package sifhPkg;

    typedef logic [`CODE_W-1:0] codeT;   // raw TDC code
    typedef logic [`BIN_W-1:0]  binT;    // bin index / SRAM address
    typedef logic [`CNT_W-1:0]  countT;  // bin content

    // measurement sequence, one pass per pair of clear and build
    typedef enum logic [2:0] {
        clearCoarse,
        buildCoarse,
        peakCoarse,
        clearFine,
        buildFine,
        peakFine,
        report
    } phaseT;

endpackage

// ==== sifhTop.sv ====
`timescale 1ns/100ps

module sifhTop (
    input  logic           clk,
    input  logic           res,
    input  logic           tdcReq,
    input  sifhPkg::codeT  tdcCode,
    output logic           tdcAck,
    output logic           tdcEnable,
    output logic           resultReq,
    output sifhPkg::codeT  resultCode,
    output sifhPkg::countT resultCount,
    output sifhPkg::countT coarseCount,
    input  logic           resultAck
);

    logic           buildStart;
    sifhPkg::binT   buildWindow;
    logic           buildFine;
    logic           buildDone;
    logic           scanStart;
    logic           scanDone;
    sifhPkg::binT   peakBin;
    sifhPkg::countT peakCount;
    logic           bldWe;
    sifhPkg::binT   bldWaddr;
    sifhPkg::countT bldWdata;
    logic           bldRe;
    sifhPkg::binT   bldRaddr;
    logic           fndRe;
    sifhPkg::binT   fndRaddr;
    logic           ramWe;
    sifhPkg::binT   ramWaddr;
    sifhPkg::countT ramWdata;
    logic           ramRe;
    sifhPkg::binT   ramRaddr;
    sifhPkg::countT ramRdata;  // shared by both masters

    sifhControl uControl (
        .clk(clk), .res(res),
        .buildStart(buildStart), .buildWindow(buildWindow),
        .buildFine(buildFine), .buildDone(buildDone),
        .scanStart(scanStart), .scanDone(scanDone),
        .peakBin(peakBin), .peakCount(peakCount),
        .bldWe(bldWe), .bldWaddr(bldWaddr), .bldWdata(bldWdata),
        .bldRe(bldRe), .bldRaddr(bldRaddr),
        .fndRe(fndRe), .fndRaddr(fndRaddr),
        .ramWe(ramWe), .ramWaddr(ramWaddr), .ramWdata(ramWdata),
        .ramRe(ramRe), .ramRaddr(ramRaddr),
        .resultReq(resultReq), .resultAck(resultAck),
        .resultCode(resultCode), .resultCount(resultCount),
        .coarseCount(coarseCount)
    );

    histBuilder uBuilder (
        .clk(clk), .res(res),
        .buildStart(buildStart), .buildFine(buildFine), .buildWindow(buildWindow),
        .tdcReq(tdcReq), .tdcCode(tdcCode), .tdcAck(tdcAck), .tdcEnable(tdcEnable),
        .we(bldWe), .waddr(bldWaddr), .wdata(bldWdata),
        .re(bldRe), .raddr(bldRaddr), .rdata(ramRdata),
        .buildDone(buildDone)
    );

    peakFinder uFinder (
        .clk(clk), .res(res),
        .scanStart(scanStart),
        .re(fndRe), .raddr(fndRaddr), .rdata(ramRdata),
        .scanDone(scanDone), .peakBin(peakBin), .peakCount(peakCount)
    );

    histRam uRam (
        .clk(clk),
        .we(ramWe), .waddr(ramWaddr), .wdata(ramWdata),
        .re(ramRe), .raddr(ramRaddr), .rdata(ramRdata)
    );

endmodule

// ==== sifh_settings.svh ====
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// TDC arrival code, upper half picks the coarse bin
`define CODE_W 10

// bin index and SRAM address width, 32 bins
`define BIN_W 5

// bin count width, counts saturate at all ones
`define CNT_W 4

// events offered to each histogram pass
`define EVENTS_PER_PASS 20

`endif

// ==== sources.f ====
+incdir+.
sifhPkg.sv
histRam.sv
histBuilder.sv
peakFinder.sv
sifhControl.sv
sifhTop.sv
tbSifh.sv

// ==== tbSifh.sv ====
`timescale 1ns/100ps
`include "sifh_settings.svh"

module tbSifh;

    localparam int NumEv      = `EVENTS_PER_PASS;
    localparam int NumBins    = 1 << `BIN_W;
    localparam int CountMax   = (1 << `CNT_W) - 1;
    localparam int AckSteps   = 1 + 3;        // req sample edge then read increment write
    localparam int ClearSteps = 1 + NumBins;  // buildStart edge then one write per bin
    localparam int MaxCycles  = 40000;        // six measurements need about 2700

    logic           clk;
    logic           res;
    logic           tdcReq;
    sifhPkg::codeT  tdcCode;
    logic           tdcAck;
    logic           tdcEnable;
    logic           resultReq;
    sifhPkg::codeT  resultCode;
    sifhPkg::countT resultCount;
    sifhPkg::countT coarseCount;
    logic           resultAck;

    sifhPkg::codeT coarseCodes [];  // events of the coarse pass
    sifhPkg::codeT fineCodes [];    // events of the fine pass
    int            binHist [];      // reference histogram
    int            cycleCount = 0;

    sifhTop u_dut (
        .clk(clk), .res(res),
        .tdcReq(tdcReq), .tdcCode(tdcCode), .tdcAck(tdcAck), .tdcEnable(tdcEnable),
        .resultReq(resultReq), .resultCode(resultCode), .resultCount(resultCount),
        .coarseCount(coarseCount), .resultAck(resultAck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            reportFailure($sformatf("simulation timed out after %0d cycles", MaxCycles));
        end
    end

    task automatic reportFailure(string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkValue(string testName, string what, int expected, int actual);
        assert (actual == expected) else begin
            reportFailure($sformatf("mismatch %s %s expected %0d actual %0d",
                testName, what, expected, actual));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #10;  // drive and sample away from the edge
    endtask

    function automatic sifhPkg::codeT makeCode(int bin, int lo);
        return `CODE_W'(bin * NumBins + lo);
    endfunction

    // one pass of the reference histogram
    task automatic modelPass(input bit finePass, input int window, output int peak,
                             output int peakCnt);
        int code;
        int b;
        binHist = new[NumBins];
        for (int i = 0; i < NumEv; i++) begin
            code = finePass ? int'(fineCodes[i]) : int'(coarseCodes[i]);
            b    = finePass ? code % NumBins : code / NumBins;
            if ((!finePass || code / NumBins == window) && binHist[b] < CountMax) begin
                binHist[b]++;  // counts stop at all ones
            end
        end
        peak = 0;
        for (int i = 1; i < NumBins; i++) begin
            if (binHist[i] > binHist[peak]) peak = i;  // first maximum wins
        end
        peakCnt = binHist[peak];
    endtask

    task automatic sendEvent(string testName, sifhPkg::codeT code);
        int steps;
        while (!tdcEnable) nextCycle();
        tdcCode = code;
        tdcReq  = 1'b1;
        steps   = 0;
        do begin
            nextCycle();
            steps++;
        end while (!tdcAck);
        checkValue(testName, "tdcAck latency", AckSteps, steps);
        tdcReq = 1'b0;
        steps  = 0;
        do begin
            nextCycle();
            steps++;
        end while (tdcAck);
        checkValue(testName, "tdcAck release", 1, steps);
    endtask

    task automatic takeResult(string testName, int expCode, int expCount, int expCoarse,
                              int holdCycles);
        while (!resultReq) nextCycle();
        checkValue(testName, "resultCode", expCode, int'(resultCode));
        checkValue(testName, "resultCount", expCount, int'(resultCount));
        checkValue(testName, "coarseCount", expCoarse, int'(coarseCount));
        if (holdCycles > 0) tdcReq = 1'b1;  // an offer the engine must ignore
        repeat (holdCycles) begin
            nextCycle();
            checkValue(testName, "resultReq while held", 1, int'(resultReq));
            checkValue(testName, "tdcEnable while held", 0, int'(tdcEnable));
            checkValue(testName, "tdcAck while held", 0, int'(tdcAck));
            checkValue(testName, "resultCode while held", expCode, int'(resultCode));
        end
        tdcReq    = 1'b0;
        resultAck = 1'b1;
        while (resultReq) nextCycle();
        resultAck = 1'b0;
    endtask

    task automatic runMeasurement(string testName, int holdCycles);
        int cBin;
        int cCnt;
        int fBin;
        int fCnt;
        modelPass(1'b0, 0, cBin, cCnt);
        modelPass(1'b1, cBin, fBin, fCnt);  // fine window is the coarse peak
        for (int i = 0; i < NumEv; i++) sendEvent(testName, coarseCodes[i]);
        for (int i = 0; i < NumEv; i++) sendEvent(testName, fineCodes[i]);
        takeResult(testName, cBin * NumBins + fBin, fCnt, cCnt, holdCycles);
    endtask

    task automatic testResetState();
        int steps;
        repeat (8) nextCycle();
        checkValue("resetState", "tdcAck in reset", 0, int'(tdcAck));
        checkValue("resetState", "tdcEnable in reset", 0, int'(tdcEnable));
        checkValue("resetState", "resultReq in reset", 0, int'(resultReq));
        res   = 1'b1;
        steps = 0;
        while (!tdcEnable) begin
            checkValue("resetState", "resultReq", 0, int'(resultReq));
            checkValue("resetState", "tdcAck", 0, int'(tdcAck));
            nextCycle();
            steps++;
        end
        checkValue("resetState", "cycles until tdcEnable", ClearSteps, steps);
    endtask

    task automatic testSaturation();
        for (int i = 0; i < NumEv; i++) begin
            coarseCodes[i] = makeCode(21, 7);
            fineCodes[i]   = makeCode(21, 7);
        end
        runMeasurement("saturation", 0);
    endtask

    task automatic testFineWindow();
        for (int i = 0; i < NumEv; i++) begin
            coarseCodes[i] = (i < 12) ? makeCode(9, i) : makeCode(i, 20);
            if (i < 6) fineCodes[i] = makeCode(9, 3);
            else if (i < 10) fineCodes[i] = makeCode(9, 17);
            else fineCodes[i] = makeCode(i, 20);  // outside bin 9
        end
        runMeasurement("fineWindow", 0);
    endtask

    task automatic testTieBreak();
        for (int i = 0; i < NumEv; i++) begin
            coarseCodes[i] = (i % 2 == 0) ? makeCode(20, i) : makeCode(6, i);
            fineCodes[i]   = (i % 2 == 0) ? makeCode(6, 25) : makeCode(6, 11);
        end
        runMeasurement("tieBreak", 0);
    endtask

    task automatic testRandom();
        int hotBin;
        int cBin;
        int cCnt;
        hotBin = $urandom % NumBins;
        for (int i = 0; i < NumEv; i++) begin
            if ($urandom % 2 == 0) coarseCodes[i] = makeCode(hotBin, $urandom % NumBins);
            else coarseCodes[i] = `CODE_W'($urandom);
        end
        modelPass(1'b0, 0, cBin, cCnt);
        for (int i = 0; i < NumEv; i++) fineCodes[i] = makeCode(cBin, $urandom % NumBins);
        runMeasurement("random", 0);
    endtask

    task automatic testBackPressure();
        for (int i = 0; i < NumEv; i++) begin
            coarseCodes[i] = makeCode(3, 30);
            fineCodes[i]   = makeCode(3, 30);
        end
        runMeasurement("backPressure", 50);
        // a leftover bin 3 or code 30 would win the next measurement
        for (int i = 0; i < NumEv; i++) begin
            if (i < 2) coarseCodes[i] = makeCode(3, 30);
            else if (i < 7) coarseCodes[i] = makeCode(28, i);
            else coarseCodes[i] = makeCode(i + 3, 0);
            if (i < 2) fineCodes[i] = makeCode(28, 30);
            else if (i < 6) fineCodes[i] = makeCode(28, 7);
            else fineCodes[i] = makeCode(i, 1);
        end
        runMeasurement("freshStart", 0);
    endtask

    initial begin
        void'($urandom(41893));
        res         = 1'b0;
        tdcReq      = 1'b0;
        tdcCode     = '0;
        resultAck   = 1'b0;
        coarseCodes = new[NumEv];
        fineCodes   = new[NumEv];
        testResetState();
        testSaturation();
        testFineWindow();
        testTieBreak();
        testRandom();
        testBackPressure();
        $display("sim passed");
        $finish;
    end

endmodule
